//--- common/core_pkg.sv
package core_pkg;

  // status carried with every slot down to the trace port
  typedef enum logic [1:0] {
    CYCLE_NO_STALL = 2'd1,
    CYCLE_RESET    = 2'd2
  } cycle_status_e;

  // operations of the arithmetic/logic unit
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    // operand b straight through, used by LUI
    ALU_PASS_B,
    // pc plus operand b, used by AUIPC
    ALU_PC_ADD
  } alu_op_e;

  // operations of the shift unit
  typedef enum logic [1:0] {
    SHIFT_SLL,
    SHIFT_SRL,
    SHIFT_SRA
  } shift_op_e;

  // which execute unit feeds writeback
  typedef enum logic [1:0] {
    WB_SRC_NONE,
    WB_SRC_ALU,
    WB_SRC_SHIFT
  } wb_src_e;

endpackage

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

  // architectural widths for RV32
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int INSN_W     = 32;

  // major opcodes of the supported groups
  localparam logic [6:0] OP_LUI     = 7'b01_101_11;
  localparam logic [6:0] OP_AUIPC   = 7'b00_101_11;
  localparam logic [6:0] OP_REG_IMM = 7'b00_100_11;
  localparam logic [6:0] OP_REG_REG = 7'b01_100_11;
  localparam logic [6:0] OP_ENVIRON = 7'b11_100_11;

  // funct3 values shared by the reg-imm and reg-reg groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 of ECALL in the system group
  localparam logic [2:0] F3_PRIV = 3'b000;

  // funct7 selects the alternate form (SUB, SRA, SRAI)
  localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b010_0000;

  // register-register layout
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } insn_r_t;

  // register-immediate layout
  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } insn_i_t;

  // one instruction word, seen through either layout
  typedef union packed {
    insn_r_t r_view;
    insn_i_t i_view;
  } insn_word_u;

endpackage

//--- hw/core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
  input  logic                              clk,
  input  logic                              rst,
  input  rv_isa_pkg::insn_word_u            insn_i,
  output logic [rv_isa_pkg::XLEN-1:0]       pc_o,
  output logic                              halt_o,
  output logic [rv_isa_pkg::XLEN-1:0]       trace_pc_o,
  output logic [rv_isa_pkg::INSN_W-1:0]     trace_insn_o,
  output core_pkg::cycle_status_e           trace_status_o,
  output logic                              trace_we_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] trace_rd_o,
  output logic [rv_isa_pkg::XLEN-1:0]       trace_data_o
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  // decode-stage levels
  logic [XLEN-1:0]       d_pc;
  logic [XLEN-1:0]       d_op_a;
  logic [XLEN-1:0]       d_op_b;
  alu_op_e               d_alu_op;
  shift_op_e             d_shift_op;
  wb_src_e               d_wb_src;
  logic [REG_ADDR_W-1:0] d_rd;
  logic                  d_rd_we;
  logic                  d_ecall;
  logic [INSN_W-1:0]     d_insn;
  cycle_status_e         d_status;

  // execute results
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] shift_result;

  // register-file write from writeback
  logic                  wb_we;
  logic [REG_ADDR_W-1:0] wb_addr;
  logic [XLEN-1:0]       wb_data;

  insn_decode #(
    .RESET_PC(RESET_PC)
  ) u_decode (
    .clk(clk), .rst(rst), .insn_i(insn_i),
    .wb_we_i(wb_we), .wb_addr_i(wb_addr), .wb_data_i(wb_data),
    .pc_o(pc_o), .d_pc_o(d_pc), .d_op_a_o(d_op_a), .d_op_b_o(d_op_b),
    .d_alu_op_o(d_alu_op), .d_shift_op_o(d_shift_op), .d_wb_src_o(d_wb_src),
    .d_rd_o(d_rd), .d_rd_we_o(d_rd_we), .d_ecall_o(d_ecall),
    .d_insn_o(d_insn), .d_status_o(d_status)
  );

  alu_unit u_alu (
    .clk(clk), .rst(rst), .d_pc_i(d_pc), .d_op_a_i(d_op_a), .d_op_b_i(d_op_b),
    .d_alu_op_i(d_alu_op), .alu_result_o(alu_result)
  );

  shift_unit u_shift (
    .clk(clk), .rst(rst), .d_op_a_i(d_op_a), .d_op_b_i(d_op_b),
    .d_shift_op_i(d_shift_op), .shift_result_o(shift_result)
  );

  writeback_select u_wb (
    .clk(clk), .rst(rst), .alu_result_i(alu_result), .shift_result_i(shift_result),
    .d_wb_src_i(d_wb_src), .d_rd_i(d_rd), .d_rd_we_i(d_rd_we), .d_ecall_i(d_ecall),
    .d_pc_i(d_pc), .d_insn_i(d_insn), .d_status_i(d_status),
    .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data), .halt_o(halt_o),
    .trace_pc_o(trace_pc_o), .trace_insn_o(trace_insn_o), .trace_status_o(trace_status_o),
    .trace_we_o(trace_we_o), .trace_rd_o(trace_rd_o), .trace_data_o(trace_data_o)
  );

endmodule

//--- hw/decode/insn_decode.sv
`timescale 1ns/1ps

module insn_decode #(
  parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                              clk,
  input  logic                              rst,
  input  rv_isa_pkg::insn_word_u            insn_i,
  input  logic                              wb_we_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_addr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       wb_data_i,
  output logic [rv_isa_pkg::XLEN-1:0]       pc_o,
  output logic [rv_isa_pkg::XLEN-1:0]       d_pc_o,
  output logic [rv_isa_pkg::XLEN-1:0]       d_op_a_o,
  output logic [rv_isa_pkg::XLEN-1:0]       d_op_b_o,
  output core_pkg::alu_op_e                 d_alu_op_o,
  output core_pkg::shift_op_e               d_shift_op_o,
  output core_pkg::wb_src_e                 d_wb_src_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] d_rd_o,
  output logic                              d_rd_we_o,
  output logic                              d_ecall_o,
  output logic [rv_isa_pkg::INSN_W-1:0]     d_insn_o,
  output core_pkg::cycle_status_e           d_status_o
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] d_pc_q;
  insn_word_u      d_insn_q;
  cycle_status_e   d_status_q;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] imm_i_sext;
  logic [XLEN-1:0] imm_u;

  // fetch pc and the fetch-to-decode register
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q       <= RESET_PC;
      d_pc_q     <= '0;
      d_insn_q   <= '0;
      d_status_q <= CYCLE_RESET;
    end else begin
      pc_q       <= pc_q + XLEN'(4);
      d_pc_q     <= pc_q;
      d_insn_q   <= insn_i;
      d_status_q <= CYCLE_NO_STALL;
    end
  end

  // immediates come from the I view, U reuses the upper 20 bits of it
  assign imm_i_sext = {{(XLEN-12){d_insn_q.i_view.imm12[11]}}, d_insn_q.i_view.imm12};
  assign imm_u = {d_insn_q.i_view.imm12, d_insn_q.i_view.rs1, d_insn_q.i_view.funct3, 12'b0};

  reg_file u_regs (
    .clk(clk), .rst(rst),
    .rs1_i(d_insn_q.r_view.rs1), .rs2_i(d_insn_q.r_view.rs2),
    .we_i(wb_we_i), .waddr_i(wb_addr_i), .wdata_i(wb_data_i),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  // each kept encoding maps to exactly one op and one source
  always_comb begin
    d_alu_op_o   = ALU_ADD;
    d_shift_op_o = SHIFT_SLL;
    d_wb_src_o   = WB_SRC_NONE;
    d_op_b_o     = rs2_data;
    d_ecall_o    = 1'b0;
    case (d_insn_q.r_view.opcode)
      OP_LUI: begin
        d_alu_op_o = ALU_PASS_B;
        d_op_b_o   = imm_u;
        d_wb_src_o = WB_SRC_ALU;
      end
      OP_AUIPC: begin
        d_alu_op_o = ALU_PC_ADD;
        d_op_b_o   = imm_u;
        d_wb_src_o = WB_SRC_ALU;
      end
      OP_REG_IMM: begin
        d_op_b_o   = imm_i_sext;
        d_wb_src_o = WB_SRC_ALU;
        case (d_insn_q.r_view.funct3)
          F3_ADD_SUB: d_alu_op_o = ALU_ADD;
          F3_SLT:     d_alu_op_o = ALU_SLT;
          F3_SLTU:    d_alu_op_o = ALU_SLTU;
          F3_XOR:     d_alu_op_o = ALU_XOR;
          F3_OR:      d_alu_op_o = ALU_OR;
          F3_AND:     d_alu_op_o = ALU_AND;
          F3_SLL: begin
            d_shift_op_o = SHIFT_SLL;
            d_wb_src_o   = (d_insn_q.r_view.funct7 == FUNCT7_BASE) ? WB_SRC_SHIFT : WB_SRC_NONE;
          end
          default: begin
            // srli / srai, the upper immediate bits pick the form
            d_shift_op_o = (d_insn_q.r_view.funct7 == FUNCT7_ALT) ? SHIFT_SRA : SHIFT_SRL;
            d_wb_src_o   = (d_insn_q.r_view.funct7 == FUNCT7_BASE ||
                            d_insn_q.r_view.funct7 == FUNCT7_ALT) ? WB_SRC_SHIFT : WB_SRC_NONE;
          end
        endcase
      end
      OP_REG_REG: begin
        if (d_insn_q.r_view.funct7 == FUNCT7_BASE) begin
          d_wb_src_o = WB_SRC_ALU;
          case (d_insn_q.r_view.funct3)
            F3_ADD_SUB: d_alu_op_o = ALU_ADD;
            F3_SLT:     d_alu_op_o = ALU_SLT;
            F3_SLTU:    d_alu_op_o = ALU_SLTU;
            F3_XOR:     d_alu_op_o = ALU_XOR;
            F3_OR:      d_alu_op_o = ALU_OR;
            F3_AND:     d_alu_op_o = ALU_AND;
            F3_SLL: begin
              d_shift_op_o = SHIFT_SLL;
              d_wb_src_o   = WB_SRC_SHIFT;
            end
            default: begin
              d_shift_op_o = SHIFT_SRL;
              d_wb_src_o   = WB_SRC_SHIFT;
            end
          endcase
        end else if (d_insn_q.r_view.funct7 == FUNCT7_ALT) begin
          if (d_insn_q.r_view.funct3 == F3_ADD_SUB) begin
            d_alu_op_o = ALU_SUB;
            d_wb_src_o = WB_SRC_ALU;
          end else if (d_insn_q.r_view.funct3 == F3_SRL_SRA) begin
            d_shift_op_o = SHIFT_SRA;
            d_wb_src_o   = WB_SRC_SHIFT;
          end
        end
      end
      OP_ENVIRON: begin
        // only ecall is kept, every other field must be zero
        d_ecall_o = ({d_insn_q.i_view.imm12, d_insn_q.i_view.rs1, d_insn_q.i_view.rd} == '0) &&
                    (d_insn_q.i_view.funct3 == F3_PRIV);
      end
      default: begin
        d_wb_src_o = WB_SRC_NONE;
      end
    endcase
  end

  assign pc_o       = pc_q;
  assign d_pc_o     = d_pc_q;
  assign d_op_a_o   = rs1_data;
  assign d_rd_o     = d_insn_q.r_view.rd;
  assign d_rd_we_o  = (d_wb_src_o != WB_SRC_NONE) && (d_insn_q.r_view.rd != '0);
  assign d_insn_o   = d_insn_q;
  assign d_status_o = d_status_q;

endmodule

//--- hw/decode/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_i,
  input  logic                              we_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       wdata_i,
  output logic [rv_isa_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_isa_pkg::XLEN-1:0]       rs2_data_o
);
  import rv_isa_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

  // write-first read port where a same-cycle write to the index is seen at once
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    logic [XLEN-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (we_i && (waddr_i == addr)) begin
      data = wdata_i;
    end else begin
      data = regs_q[addr];
    end
    return data;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      regs_q <= '{default: '0};
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

endmodule

//--- hw/execute/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [rv_isa_pkg::XLEN-1:0] d_pc_i,
  input  logic [rv_isa_pkg::XLEN-1:0] d_op_a_i,
  input  logic [rv_isa_pkg::XLEN-1:0] d_op_b_i,
  input  core_pkg::alu_op_e           d_alu_op_i,
  output logic [rv_isa_pkg::XLEN-1:0] alu_result_o
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  alu_op_e         x_op_q;
  logic [XLEN-1:0] x_pc_q;
  logic [XLEN-1:0] x_a_q;
  logic [XLEN-1:0] x_b_q;
  logic [XLEN-1:0] add_base;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            lt_signed;
  logic            lt_unsigned;

  // decode-to-execute edge
  always_ff @(posedge clk) begin
    if (rst) begin
      x_op_q <= ALU_ADD;
    end else begin
      x_op_q <= d_alu_op_i;
    end
  end

  always_ff @(posedge clk) begin
    x_pc_q <= d_pc_i;
    x_a_q  <= d_op_a_i;
    x_b_q  <= d_op_b_i;
  end

  // one adder serves ADD(I) and AUIPC
  assign add_base = (x_op_q == ALU_PC_ADD) ? x_pc_q : x_a_q;
  assign sum      = add_base + x_b_q;
  assign diff     = x_a_q - x_b_q;

  assign lt_signed   = $signed(x_a_q) < $signed(x_b_q);
  assign lt_unsigned = x_a_q < x_b_q;

  always_comb begin
    case (x_op_q)
      ALU_ADD,
      ALU_PC_ADD: alu_result_o = sum;
      ALU_SUB:    alu_result_o = diff;
      ALU_SLT:    alu_result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   alu_result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    alu_result_o = x_a_q ^ x_b_q;
      ALU_OR:     alu_result_o = x_a_q | x_b_q;
      ALU_AND:    alu_result_o = x_a_q & x_b_q;
      // lui, operand b already holds imm << 12
      ALU_PASS_B: alu_result_o = x_b_q;
      default:    alu_result_o = '0;
    endcase
  end

endmodule

//--- hw/execute/shift_unit.sv
`timescale 1ns/1ps

module shift_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [rv_isa_pkg::XLEN-1:0] d_op_a_i,
  input  logic [rv_isa_pkg::XLEN-1:0] d_op_b_i,
  input  core_pkg::shift_op_e         d_shift_op_i,
  output logic [rv_isa_pkg::XLEN-1:0] shift_result_o
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  shift_op_e       x_op_q;
  logic [XLEN-1:0] x_a_q;
  logic [4:0]      x_shamt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_op_q <= SHIFT_SLL;
    end else begin
      x_op_q <= d_shift_op_i;
    end
  end

  // only the low 5 bits of operand b form the shift amount
  always_ff @(posedge clk) begin
    x_a_q     <= d_op_a_i;
    x_shamt_q <= d_op_b_i[4:0];
  end

  always_comb begin
    case (x_op_q)
      SHIFT_SLL: shift_result_o = x_a_q << x_shamt_q;
      SHIFT_SRL: shift_result_o = x_a_q >> x_shamt_q;
      // sign fill
      SHIFT_SRA: shift_result_o = XLEN'($signed(x_a_q) >>> x_shamt_q);
      default:   shift_result_o = '0;
    endcase
  end

endmodule

//--- hw/writeback_select.sv
`timescale 1ns/1ps

module writeback_select (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [rv_isa_pkg::XLEN-1:0]       alu_result_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       shift_result_i,
  input  core_pkg::wb_src_e                 d_wb_src_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] d_rd_i,
  input  logic                              d_rd_we_i,
  input  logic                              d_ecall_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       d_pc_i,
  input  logic [rv_isa_pkg::INSN_W-1:0]     d_insn_i,
  input  core_pkg::cycle_status_e           d_status_i,
  output logic                              wb_we_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_addr_o,
  output logic [rv_isa_pkg::XLEN-1:0]       wb_data_o,
  output logic                              halt_o,
  output logic [rv_isa_pkg::XLEN-1:0]       trace_pc_o,
  output logic [rv_isa_pkg::INSN_W-1:0]     trace_insn_o,
  output core_pkg::cycle_status_e           trace_status_o,
  output logic                              trace_we_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] trace_rd_o,
  output logic [rv_isa_pkg::XLEN-1:0]       trace_data_o
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  // execute-stage control
  wb_src_e               x_src_q;
  logic [REG_ADDR_W-1:0] x_rd_q;
  logic                  x_we_q;
  logic                  x_ecall_q;
  logic [XLEN-1:0]       x_pc_q;
  logic [INSN_W-1:0]     x_insn_q;
  cycle_status_e         x_status_q;
  logic [XLEN-1:0]       x_result;

  // writeback register
  logic                  w_we_q;
  logic [REG_ADDR_W-1:0] w_rd_q;
  logic [XLEN-1:0]       w_data_q;
  logic [XLEN-1:0]       w_pc_q;
  logic [INSN_W-1:0]     w_insn_q;
  cycle_status_e         w_status_q;
  logic                  halt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_src_q    <= WB_SRC_NONE;
      x_we_q     <= 1'b0;
      x_ecall_q  <= 1'b0;
      x_pc_q     <= '0;
      x_insn_q   <= '0;
      x_status_q <= CYCLE_RESET;
      w_we_q     <= 1'b0;
      w_pc_q     <= '0;
      w_insn_q   <= '0;
      w_status_q <= CYCLE_RESET;
      halt_q     <= 1'b0;
    end else begin
      x_src_q    <= d_wb_src_i;
      x_we_q     <= d_rd_we_i;
      x_ecall_q  <= d_ecall_i;
      x_pc_q     <= d_pc_i;
      x_insn_q   <= d_insn_i;
      x_status_q <= d_status_i;
      w_we_q     <= x_we_q;
      w_pc_q     <= x_pc_q;
      w_insn_q   <= x_insn_q;
      w_status_q <= x_status_q;
      // set as ecall enters writeback, held until reset
      halt_q     <= halt_q | x_ecall_q;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    x_rd_q   <= d_rd_i;
    w_rd_q   <= x_rd_q;
    w_data_q <= x_result;
  end

  always_comb begin
    case (x_src_q)
      WB_SRC_ALU:   x_result = alu_result_i;
      WB_SRC_SHIFT: x_result = shift_result_i;
      default:      x_result = '0;
    endcase
  end

  assign wb_we_o        = w_we_q;
  assign wb_addr_o      = w_rd_q;
  assign wb_data_o      = w_data_q;
  assign halt_o         = halt_q;
  assign trace_pc_o     = w_pc_q;
  assign trace_insn_o   = w_insn_q;
  assign trace_status_o = w_status_q;
  assign trace_we_o     = w_we_q;
  assign trace_rd_o     = w_rd_q;
  assign trace_data_o   = w_data_q;

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module core_tb -o core_sim
./obj_dir/core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
  exit 1
fi
if ! grep -q "No errors" sim.log; then
  exit 1
fi
exit 0

//--- tests/core_program.svh
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

// every instruction is followed by one NOP, so a consumer sits two slots behind
task automatic put(input logic [31:0] insn);
  prog[prog_len] = insn;
  prog[prog_len + 1] = NOP;
  prog_len = prog_len + 2;
endtask

task automatic clear_program();
  for (int i = 0; i < PROG_MAX; i++) begin
    prog[i] = NOP;
  end
  prog_len = 0;
endtask

function automatic logic [4:0] random_rd();
  return 5'(3 + ($unsigned($random(seed)) % 29));
endfunction

// lui then addi where the +0x800 undoes the sign extension of the low part
task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
  logic [31:0] upper;
  upper = value + 32'h800;
  put({upper[31:12], rd, 7'b0110111});
  put(enc_i(value[11:0], rd, 3'd0, rd, 7'b0010011));
endtask

task automatic build_alu_program();
  logic [31:0] a;
  logic [31:0] b;
  clear_program();
  for (int k = 0; k < 3; k++) begin
    a = $random(seed);
    b = $random(seed);
    // opposite signs so signed and unsigned compares disagree
    b[31] = ~a[31];
    load_reg(5'd1, a);
    load_reg(5'd2, b);
    for (int f3 = 0; f3 < 8; f3++) begin
      put(enc_r(7'h00, 5'd2, 5'd1, 3'(f3), random_rd(), 7'b0110011));
    end
    put(enc_r(7'h20, 5'd2, 5'd1, 3'd0, random_rd(), 7'b0110011));
    put(enc_r(7'h20, 5'd2, 5'd1, 3'd5, random_rd(), 7'b0110011));
    foreach (ri_f3[j]) begin
      put(enc_i(12'($random(seed)), 5'd1, ri_f3[j], random_rd(), 7'b0010011));
    end
    put({20'($random(seed)), random_rd(), 7'b0110111});
    put({20'($random(seed)), random_rd(), 7'b0010111});
  end
endtask

task automatic build_shift_program();
  logic [31:0] a;
  clear_program();
  for (int k = 0; k < 4; k++) begin
    a = $random(seed);
    a[31] = k[0];
    load_reg(5'd1, a);
    load_reg(5'd2, $random(seed));
    put(enc_i({7'h00, 5'($random(seed))}, 5'd1, 3'd1, random_rd(), 7'b0010011));
    put(enc_i({7'h00, 5'($random(seed))}, 5'd1, 3'd5, random_rd(), 7'b0010011));
    put(enc_i({7'h20, 5'($random(seed))}, 5'd1, 3'd5, random_rd(), 7'b0010011));
    put(enc_r(7'h00, 5'd2, 5'd1, 3'd1, random_rd(), 7'b0110011));
    put(enc_r(7'h00, 5'd2, 5'd1, 3'd5, random_rd(), 7'b0110011));
    put(enc_r(7'h20, 5'd2, 5'd1, 3'd5, random_rd(), 7'b0110011));
  end
endtask

//--- tests/core_tb.sv
`timescale 1ns/1ps

module core_tb;

  localparam logic [31:0] RESET_PC = 32'h0000_0100;
  localparam logic [31:0] NOP      = 32'h0000_0013;
  localparam logic [31:0] ECALL    = 32'h0000_0073;
  localparam int PROG_MAX = 512;
  localparam int RUN_TIMEOUT = 2000;

  logic clk;
  logic rst;
  rv_isa_pkg::insn_word_u insn_i;
  logic [31:0] pc_o;
  logic halt_o;
  logic [31:0] trace_pc_o;
  logic [31:0] trace_insn_o;
  core_pkg::cycle_status_e trace_status_o;
  logic trace_we_o;
  logic [4:0] trace_rd_o;
  logic [31:0] trace_data_o;

  logic [31:0] prog [0:PROG_MAX-1];
  logic        exp_we [0:PROG_MAX-1];
  logic [4:0]  exp_rd [0:PROG_MAX-1];
  logic [31:0] exp_data [0:PROG_MAX-1];
  logic [31:0] model_regs [0:31];
  logic [2:0]  ri_f3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
  int prog_len;
  int seed = 32'h5736;
  int cyc;
  int checks;
  int errors;
  int tests;
  logic halt_seen;

  `include "core_program.svh"

  core_top #(.RESET_PC(RESET_PC)) u_dut (
    .clk(clk), .rst(rst), .insn_i(insn_i), .pc_o(pc_o), .halt_o(halt_o),
    .trace_pc_o(trace_pc_o), .trace_insn_o(trace_insn_o), .trace_status_o(trace_status_o),
    .trace_we_o(trace_we_o), .trace_rd_o(trace_rd_o), .trace_data_o(trace_data_o)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] fetch(input logic [31:0] addr);
    int idx;
    idx = int'((addr - RESET_PC) >> 2);
    if (addr < RESET_PC || idx >= PROG_MAX) begin
      return NOP;
    end
    return prog[idx];
  endfunction

  // instruction memory driven just after each rising edge
  always @(posedge clk) begin
    #1 insn_i = fetch(pc_o);
  end

  always @(posedge clk) begin
    cyc <= rst ? 0 : cyc + 1;
  end

  // reference model walking the program in order with its own registers
  task automatic compute_expected();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < PROG_MAX; i++) begin
      w = prog[i];
      pc = RESET_PC + 32'(4 * i);
      a = model_regs[w[19:15]];
      b = (w[6:0] == 7'b0110011) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
      exp_rd[i] = w[11:7];
      exp_we[i] = (w[11:7] != 0) && (w[6:0] inside {7'b0110111, 7'b0010111,
                                                     7'b0010011, 7'b0110011});
      case (w[6:0])
        7'b0110111: exp_data[i] = {w[31:12], 12'b0};
        7'b0010111: exp_data[i] = pc + {w[31:12], 12'b0};
        default: begin
          case (w[14:12])
            3'd0: exp_data[i] = (w[6:0] == 7'b0110011 && w[30]) ? a - b : a + b;
            3'd1: exp_data[i] = a << b[4:0];
            3'd2: exp_data[i] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: exp_data[i] = (a < b) ? 32'd1 : 32'd0;
            3'd4: exp_data[i] = a ^ b;
            3'd5: exp_data[i] = w[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: exp_data[i] = a | b;
            default: exp_data[i] = a & b;
          endcase
        end
      endcase
      if (exp_we[i]) begin
        model_regs[exp_rd[i]] = exp_data[i];
      end
    end
  endtask

  task automatic check(input string name, input logic [31:0] expv, input logic [31:0] act);
    checks++;
    assert (expv === act) else begin
      errors++;
      $display("FAILED at %0t: %s expected %h got %h", $time, name, expv, act);
    end
  endtask

  // trace, pc and halt are sampled mid-cycle where they are stable
  always @(negedge clk) begin
    int idx;
    if (!rst) begin
      check("pc_o", RESET_PC + 32'(4 * cyc), pc_o);
      if (cyc < 3) begin
        check("trace_status_o", 32'(core_pkg::CYCLE_RESET), 32'(trace_status_o));
        check("trace_we_o", 32'd0, 32'(trace_we_o));
      end else if (cyc - 3 < PROG_MAX) begin
        idx = cyc - 3;
        check("trace_status_o", 32'(core_pkg::CYCLE_NO_STALL), 32'(trace_status_o));
        check("trace_pc_o", RESET_PC + 32'(4 * idx), trace_pc_o);
        check("trace_insn_o", prog[idx], trace_insn_o);
        check("trace_we_o", 32'(exp_we[idx]), 32'(trace_we_o));
        if (exp_we[idx]) begin
          check("trace_rd_o", 32'(exp_rd[idx]), 32'(trace_rd_o));
          check("trace_data_o", exp_data[idx], trace_data_o);
        end
        if (prog[idx] == ECALL) begin
          halt_seen = 1'b1;
        end
      end
      check("halt_o", 32'(halt_seen), 32'(halt_o));
    end
  end

  task automatic run_program(input string name);
    int start_errors;
    int n;
    start_errors = errors;
    compute_expected();
    #1 rst = 1'b1;
    halt_seen = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    n = 0;
    while (cyc < prog_len + 5 && n < RUN_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (n >= RUN_TIMEOUT) begin
      errors++;
      $display("timeout: program %s did not run to its end", name);
    end
    tests++;
    $display("test %s finished with %0d failing checks", name, errors - start_errors);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    insn_i = NOP;
    halt_seen = 1'b0;
    build_alu_program();
    run_program("alu");
    build_shift_program();
    run_program("shift");
    // x0 writes are dropped, and a consumer two slots behind sees the producer
    clear_program();
    load_reg(5'd1, $random(seed));
    put(enc_i(12'h07b, 5'd1, 3'd0, 5'd0, 7'b0010011));
    put({20'habcde, 5'd0, 7'b0110111});
    put(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd5, 7'b0110011));
    put(enc_r(7'h00, 5'd1, 5'd0, 3'd6, 5'd6, 7'b0110011));
    put(enc_r(7'h00, 5'd6, 5'd6, 3'd0, 5'd7, 7'b0110011));
    run_program("x0_and_hazard");
    clear_program();
    load_reg(5'd3, $random(seed));
    put(ECALL);
    put(enc_i(12'h001, 5'd3, 3'd0, 5'd4, 7'b0010011));
    run_program("ecall_halt");
    // halt must clear on the next reset
    clear_program();
    put(enc_i(12'h011, 5'd0, 3'd0, 5'd8, 7'b0010011));
    run_program("reset_after_halt");
    $display("tests: %0d, checks: %0d, failures: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+tests
common/rv_isa_pkg.sv
common/core_pkg.sv
hw/decode/reg_file.sv
hw/decode/insn_decode.sv
hw/execute/alu_unit.sv
hw/execute/shift_unit.sv
hw/writeback_select.sv
hw/core_top.sv
tests/core_tb.sv
